// ==== Makefile ====
SIM := obj_dir/memory_game_sim

compile:
	verilator --binary --timing --assert -j 0 --top-module memory_game_tb \
		-f verilog.f -o memory_game_sim

# Assertion failures are counted so the run still reaches the final report
run: compile
	./$(SIM) +verilator+error+limit+1000 | tee sim.log
	grep -qF "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean

// ==== source/button_conditioner.sv ====
`timescale 1ns/10ps

module button_conditioner #(
    parameter int DEBOUNCE_LEN = 7
) (
    input  logic clk,
    input  logic rst,
    input  logic btn_i,
    output logic pulse_o
);

    logic [DEBOUNCE_LEN-1:0] samples;
    logic                    pressed;
    logic                    pressed_d;

    // Last DEBOUNCE_LEN samples of the raw button
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples <= '0;
        end else begin
            samples <= {samples[DEBOUNCE_LEN-2:0], btn_i};
        end
    end

    assign pressed = &samples;

    // One cycle per new press
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pressed_d <= 1'b0;
            pulse_o   <= 1'b0;
        end else begin
            pressed_d <= pressed;
            pulse_o   <= pressed & ~pressed_d;
        end
    end

endmodule

// ==== source/card_board.sv ====
`timescale 1ns/10ps

module card_board (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start_pulse_i,
    input  logic                         pick_i,
    input  memory_game_pkg::card_idx_t   pick_card_i,
    input  logic                         confirm_i,
    input  logic                         hint_i,
    output memory_game_pkg::game_phase_t phase_o,
    output memory_game_pkg::card_view_t  card_view_o,
    output memory_game_pkg::card_mask_t  face_up_o,
    output memory_game_pkg::pair_count_t pair_count_o,
    output logic                         ready_o
);

    import memory_game_pkg::*;

    game_phase_t phase;
    game_phase_t phase_next;
    card_mask_t  shown;
    card_mask_t  matched;
    pair_count_t pair_count;
    logic        ready;
    logic        first_valid;
    card_idx_t   first_card;
    logic        pick_ok;
    pair_id_t    pick_pair;
    pair_id_t    first_pair;

    always_comb begin
        case (phase)
            PH_IDLE:    phase_next = PH_PREVIEW;
            PH_PREVIEW: phase_next = PH_PLAY;
            PH_PLAY:    phase_next = PH_FINISH;
            default:    phase_next = PH_IDLE;
        endcase
    end

    // A pick must name an unmatched card other than the held first pick
    assign pick_ok = (phase == PH_PLAY) && pick_i && ready && !hint_i &&
                     !matched[pick_card_i] &&
                     !(first_valid && (first_card == pick_card_i));

    assign pick_pair  = pair_id_t'(pick_card_i % NUM_PAIRS);
    assign first_pair = pair_id_t'(first_card % NUM_PAIRS);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase       <= PH_IDLE;
            shown       <= '0;
            matched     <= '0;
            pair_count  <= '0;
            ready       <= 1'b1;
            first_valid <= 1'b0;
        end else if (start_pulse_i) begin
            phase       <= phase_next;
            ready       <= 1'b1;
            first_valid <= 1'b0;
            case (phase_next)
                PH_PREVIEW: begin
                    shown   <= '1;
                    matched <= '0;
                end
                PH_PLAY: begin
                    shown      <= '0;
                    matched    <= '0;
                    pair_count <= '0;
                end
                PH_FINISH: begin
                    shown   <= '1;
                    matched <= '1;
                end
                default: begin
                    shown      <= '0;
                    matched    <= '0;
                    pair_count <= '0;
                end
            endcase
        end else if ((phase == PH_PLAY) && confirm_i && !ready) begin
            // Turn unmatched cards face down again
            shown       <= shown & matched;
            first_valid <= 1'b0;
            ready       <= 1'b1;
        end else if (pick_ok) begin
            shown[pick_card_i] <= 1'b1;
            if (!first_valid) begin
                first_valid <= 1'b1;
            end else begin
                ready <= 1'b0;
                if (pick_pair == first_pair) begin
                    matched[pick_card_i] <= 1'b1;
                    matched[first_card]  <= 1'b1;
                    pair_count           <= pair_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pick_ok && !first_valid) begin
            first_card <= pick_card_i;
        end
    end

    assign phase_o      = phase;
    assign card_view_o  = '{shown: shown, matched: matched};
    assign pair_count_o = pair_count;
    assign ready_o      = ready;

    // Hint overrides the display only while playing
    assign face_up_o = (hint_i && (phase == PH_PLAY)) ? '1 : (shown | matched);

endmodule

// ==== source/memory_game_pkg.sv ====
package memory_game_pkg;

    typedef logic [9:0]  coord_t;
    typedef logic [3:0]  card_idx_t;
    typedef logic [2:0]  pair_id_t;
    typedef logic [3:0]  pair_count_t;
    typedef logic [11:0] rgb_t;
    typedef logic [15:0] card_mask_t;

    typedef enum logic [1:0] {
        PH_IDLE    = 2'd0,
        PH_PREVIEW = 2'd1,
        PH_PLAY    = 2'd2,
        PH_FINISH  = 2'd3
    } game_phase_t;

    typedef struct packed {
        coord_t h;
        coord_t v;
        logic   active;
        logic   hsync_n;
        logic   vsync_n;
    } raster_t;

    typedef struct packed {
        card_mask_t shown;
        card_mask_t matched;
    } card_view_t;

    // 640x480 at one pixel per clk
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_TOTAL  = 800;
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_TOTAL  = 525;

    // Card size on the half-scaled raster
    localparam int CARD_W = 80;
    localparam int CARD_H = 60;

    localparam int NUM_PAIRS = 8;

    localparam rgb_t PALETTE [NUM_PAIRS] = '{
        12'hF00, 12'h0F0, 12'h00F, 12'hFF0,
        12'hF0F, 12'h0FF, 12'hF80, 12'hFFF
    };

    localparam rgb_t BACK_COLOR = 12'h448;

endpackage

// ==== source/memory_game_top.sv ====
`timescale 1ns/10ps

module memory_game_top #(
    parameter int DEBOUNCE_LEN = 7
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start_i,
    input  logic                         pick_i,
    input  memory_game_pkg::card_idx_t   pick_card_i,
    input  logic                         confirm_i,
    input  logic                         hint_i,
    output memory_game_pkg::rgb_t        rgb_o,
    output logic                         hsync_o,
    output logic                         vsync_o,
    output memory_game_pkg::game_phase_t phase_o,
    output memory_game_pkg::card_view_t  card_view_o,
    output memory_game_pkg::pair_count_t pair_count_o,
    output logic                         ready_o
);

    import memory_game_pkg::*;

    logic       start_pulse;
    raster_t    raster;
    card_mask_t face_up;

    button_conditioner #(
        .DEBOUNCE_LEN(DEBOUNCE_LEN)
    ) u_start_btn (
        .clk     (clk),
        .rst     (rst),
        .btn_i   (start_i),
        .pulse_o (start_pulse)
    );

    vga_timing u_timing (
        .clk      (clk),
        .rst      (rst),
        .raster_o (raster)
    );

    card_board u_board (
        .clk           (clk),
        .rst           (rst),
        .start_pulse_i (start_pulse),
        .pick_i        (pick_i),
        .pick_card_i   (pick_card_i),
        .confirm_i     (confirm_i),
        .hint_i        (hint_i),
        .phase_o       (phase_o),
        .card_view_o   (card_view_o),
        .face_up_o     (face_up),
        .pair_count_o  (pair_count_o),
        .ready_o       (ready_o)
    );

    pixel_compose u_compose (
        .clk       (clk),
        .rst       (rst),
        .raster_i  (raster),
        .face_up_i (face_up),
        .rgb_o     (rgb_o),
        .hsync_o   (hsync_o),
        .vsync_o   (vsync_o)
    );

endmodule

// ==== source/pixel_compose.sv ====
`timescale 1ns/10ps

module pixel_compose (
    input  logic                        clk,
    input  logic                        rst,
    input  memory_game_pkg::raster_t    raster_i,
    input  memory_game_pkg::card_mask_t face_up_i,
    output memory_game_pkg::rgb_t       rgb_o,
    output logic                        hsync_o,
    output logic                        vsync_o
);

    import memory_game_pkg::*;

    coord_t    x_half;
    coord_t    y_half;
    logic [1:0] grid_col;
    logic [1:0] grid_row;
    card_idx_t card;
    pair_id_t  pair;
    rgb_t      colour;

    // Board is drawn on a half-scaled 320x240 grid
    assign x_half = raster_i.h >> 1;
    assign y_half = raster_i.v >> 1;

    assign grid_col = 2'(x_half / CARD_W);
    assign grid_row = 2'(y_half / CARD_H);

    // Row-major card number
    assign card = {grid_row, grid_col};
    assign pair = pair_id_t'(card % NUM_PAIRS);

    always_comb begin
        if (!raster_i.active) begin
            colour = '0;
        end else if (face_up_i[card]) begin
            colour = PALETTE[pair];
        end else begin
            colour = BACK_COLOR;
        end
    end

    // Colour and syncs leave together, one cycle behind the raster
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb_o   <= '0;
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else begin
            rgb_o   <= colour;
            hsync_o <= raster_i.hsync_n;
            vsync_o <= raster_i.vsync_n;
        end
    end

endmodule

// ==== source/vga_timing.sv ====
`timescale 1ns/10ps

module vga_timing (
    input  logic                     clk,
    input  logic                     rst,
    output memory_game_pkg::raster_t raster_o
);

    import memory_game_pkg::*;

    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    coord_t h_cnt;
    coord_t v_cnt;
    logic   h_wrap;

    assign h_wrap = (h_cnt == coord_t'(H_TOTAL - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
        end else if (h_wrap) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Line counter steps once per horizontal wrap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v_cnt <= '0;
        end else if (h_wrap) begin
            if (v_cnt == coord_t'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        raster_o.h       = h_cnt;
        raster_o.v       = v_cnt;
        raster_o.active  = (h_cnt < coord_t'(H_ACTIVE)) && (v_cnt < coord_t'(V_ACTIVE));
        // Both syncs are active low
        raster_o.hsync_n = !((h_cnt >= coord_t'(H_SYNC_START)) &&
                             (h_cnt <  coord_t'(H_SYNC_END)));
        raster_o.vsync_n = !((v_cnt >= coord_t'(V_SYNC_START)) &&
                             (v_cnt <  coord_t'(V_SYNC_END)));
    end

endmodule

// ==== verification/memory_game_props.sv ====
`timescale 1ns/10ps

module memory_game_props (
    input logic                     clk,
    input logic                     rst,
    input memory_game_pkg::rgb_t    rgb_i,
    input logic                     hsync_i,
    input logic                     vsync_i,
    input memory_game_pkg::raster_t raster_i
);

    import memory_game_pkg::*;

    int   hlen_err = 0;
    int   hper_err = 0;
    int   vlen_err = 0;
    int   vper_err = 0;
    int   rgb_err  = 0;
    int   err_total;
    int   h_low;
    int   h_per;
    int   v_low;
    int   v_per;
    logic h_seen;
    logic v_seen;
    logic hsync_d;
    logic vsync_d;
    logic active_d;
    logic h_rise;
    logic h_fall;
    logic v_rise;
    logic v_fall;

    assign h_rise    = hsync_i && !hsync_d;
    assign h_fall    = !hsync_i && hsync_d;
    assign v_rise    = vsync_i && !vsync_d;
    assign v_fall    = !vsync_i && vsync_d;
    assign err_total = hlen_err + hper_err + vlen_err + vper_err + rgb_err;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
            active_d <= 1'b1;
            h_seen   <= 1'b0;
            v_seen   <= 1'b0;
            h_low    <= 0;
            v_low    <= 0;
            h_per    <= 0;
            v_per    <= 0;
        end else begin
            hsync_d  <= hsync_i;
            vsync_d  <= vsync_i;
            active_d <= raster_i.active;
            h_low    <= hsync_i ? 0 : h_low + 1;
            v_low    <= vsync_i ? 0 : v_low + 1;
            // Periods restart on each falling sync edge
            h_per    <= h_fall ? 1 : h_per + 1;
            v_per    <= v_fall ? 1 : v_per + 1;
            h_seen   <= h_seen | h_fall;
            v_seen   <= v_seen | v_fall;
        end
    end

    assert property (@(posedge clk) disable iff (rst) h_rise |-> h_low == H_SYNC)
        else begin
            $error("hsync was low for %0d cycles", h_low);
            hlen_err++;
        end

    assert property (@(posedge clk) disable iff (rst) (h_fall && h_seen) |-> h_per == H_TOTAL)
        else begin
            $error("hsync period was %0d cycles", h_per);
            hper_err++;
        end

    // Two lines of low vsync
    assert property (@(posedge clk) disable iff (rst) v_rise |-> v_low == V_SYNC * H_TOTAL)
        else begin
            $error("vsync was low for %0d cycles", v_low);
            vlen_err++;
        end

    assert property (@(posedge clk) disable iff (rst)
        (v_fall && v_seen) |-> v_per == V_TOTAL * H_TOTAL)
        else begin
            $error("vsync period was %0d cycles", v_per);
            vper_err++;
        end

    // Colour lags the raster by one cycle
    assert property (@(posedge clk) disable iff (rst) !active_d |-> rgb_i == '0)
        else begin
            $error("colour %h shown outside the active area", rgb_i);
            rgb_err++;
        end

endmodule

bind memory_game_top memory_game_props u_props (
    .clk      (clk),
    .rst      (rst),
    .rgb_i    (rgb_o),
    .hsync_i  (hsync_o),
    .vsync_i  (vsync_o),
    .raster_i (raster)
);

// ==== verification/memory_game_tb.sv ====
`timescale 1ns/10ps

module memory_game_tb;

    import memory_game_pkg::*;

    localparam int DEB         = 7;
    localparam int FRAME       = H_TOTAL * V_TOTAL;
    // Five frames of display checks plus the strobes
    localparam int STIM_CYCLES = 5 * FRAME + 4000;
    localparam int LIMIT       = 3 * FRAME + STIM_CYCLES;

    logic        clk;
    logic        rst;
    logic        start_i;
    logic        pick_i;
    card_idx_t   pick_card_i;
    logic        confirm_i;
    logic        hint_i;
    rgb_t        rgb_o;
    logic        hsync_o;
    logic        vsync_o;
    game_phase_t phase_o;
    card_view_t  card_view_o;
    pair_count_t pair_count_o;
    logic        ready_o;

    // Board model
    game_phase_t m_phase;
    card_mask_t  m_shown;
    card_mask_t  m_matched;
    pair_count_t m_count;
    logic        m_ready;
    logic        m_first_valid;
    card_idx_t   m_first;
    card_mask_t  model_fu;
    card_mask_t  fu_seen;

    int          rh;
    int          rv;
    int          centres    = 0;
    int          cycles     = 0;
    int          state_errs = 0;
    int          pixel_errs = 0;
    string       tname;
    logic [31:0] seed;

    memory_game_top #(
        .DEBOUNCE_LEN(DEB)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Lowest numbered card not yet matched
    function automatic card_idx_t unmatched_card();
        card_idx_t c;
        c = '0;
        for (int i = 15; i >= 0; i--) begin
            if (!m_matched[i]) begin
                c = card_idx_t'(i);
            end
        end
        return c;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s %s: expected %0h, got %0h", tname, what, exp, act);
            state_errs++;
        end
    endtask

    task automatic compare_state();
        check_val("phase", 32'(m_phase), 32'(phase_o));
        check_val("card_view", {m_shown, m_matched}, card_view_o);
        check_val("pair_count", 32'(m_count), 32'(pair_count_o));
        check_val("ready", 32'(m_ready), 32'(ready_o));
    endtask

    task automatic step_phase();
        m_ready       = 1'b1;
        m_first_valid = 1'b0;
        case (m_phase)
            PH_IDLE: begin
                m_phase = PH_PREVIEW;
                m_shown = '1;
            end
            PH_PREVIEW: begin
                m_phase   = PH_PLAY;
                m_shown   = '0;
                m_matched = '0;
                m_count   = '0;
            end
            PH_PLAY: begin
                m_phase   = PH_FINISH;
                m_shown   = '1;
                m_matched = '1;
            end
            default: begin
                m_phase   = PH_IDLE;
                m_shown   = '0;
                m_matched = '0;
                m_count   = '0;
            end
        endcase
    endtask

    // A full press steps the phase DEB + 2 edges after it starts
    task automatic press_start(input bit full);
        start_i = 1'b1;
        if (full) begin
            repeat (DEB + 1) tick();
            check_val("phase before step", 32'(m_phase), 32'(phase_o));
            tick();
            step_phase();
        end else begin
            repeat (DEB - 1) tick();
            start_i = 1'b0;
            repeat (DEB + 3) tick();
        end
        start_i = 1'b0;
        compare_state();
        tick();
    endtask

    task automatic do_pick(input card_idx_t c);
        logic ok;
        ok = (m_phase == PH_PLAY) && m_ready && !hint_i && !m_matched[c] &&
             !(m_first_valid && (m_first == c));
        pick_i      = 1'b1;
        pick_card_i = c;
        tick();
        pick_i = 1'b0;
        if (ok) begin
            m_shown[c] = 1'b1;
            if (!m_first_valid) begin
                m_first_valid = 1'b1;
                m_first       = c;
            end else begin
                m_ready = 1'b0;
                if ((c % NUM_PAIRS) == (m_first % NUM_PAIRS)) begin
                    m_matched[c]       = 1'b1;
                    m_matched[m_first] = 1'b1;
                    m_count            = m_count + 1'b1;
                end
            end
        end
        compare_state();
    endtask

    task automatic do_confirm();
        logic ok;
        ok        = (m_phase == PH_PLAY) && !m_ready;
        confirm_i = 1'b1;
        tick();
        confirm_i = 1'b0;
        if (ok) begin
            m_shown       = m_shown & m_matched;
            m_first_valid = 1'b0;
            m_ready       = 1'b1;
        end
        compare_state();
    endtask

    // One random round of picks followed by a confirm
    task automatic play_round();
        card_idx_t a;
        seed = xorshift(seed);
        a    = seed[3:0];
        do_pick(a);
        do_pick(a);
        // Partner card half the time
        do_pick(seed[4] ? (a ^ 4'd8) : seed[11:8]);
        do_pick(seed[15:12]);
        do_confirm();
    endtask

    task automatic wait_centres(input string name);
        int target;
        tname  = name;
        target = centres + 16;
        while (centres < target) begin
            tick();
        end
    endtask

    assign model_fu = (hint_i && (m_phase == PH_PLAY)) ? '1 : (m_shown | m_matched);

    // rgb_o shows the face-up mask of one edge earlier
    always @(posedge clk) begin
        fu_seen <= model_fu;
    end

    // Position of the pixel whose colour rgb_o holds
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            rh <= H_TOTAL - 1;
            rv <= V_TOTAL - 1;
        end else if (rh == H_TOTAL - 1) begin
            rh <= 0;
            rv <= (rv == V_TOTAL - 1) ? 0 : rv + 1;
        end else begin
            rh <= rh + 1;
        end
    end

    always @(negedge clk) begin : centre_check
        card_idx_t card;
        pair_id_t  pair;
        rgb_t      exp;
        if (!rst && (rh < H_ACTIVE) && (rv < V_ACTIVE) &&
            (rh % (2 * CARD_W) == CARD_W) && (rv % (2 * CARD_H) == CARD_H)) begin
            card = card_idx_t'((rv / (2 * CARD_H)) * 4 + rh / (2 * CARD_W));
            pair = pair_id_t'(card % NUM_PAIRS);
            exp  = fu_seen[card] ? PALETTE[pair] : BACK_COLOR;
            assert (rgb_o == exp) else begin
                $display("[FAIL] %s card %0d: expected %h, got %h", tname, card, exp, rgb_o);
                pixel_errs++;
            end
            centres++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        int        total;
        card_idx_t hint_card;
        rst           = 1'b1;
        start_i       = 1'b0;
        pick_i        = 1'b0;
        pick_card_i   = '0;
        confirm_i     = 1'b0;
        hint_i        = 1'b0;
        m_phase       = PH_IDLE;
        m_shown       = '0;
        m_matched     = '0;
        m_count       = '0;
        m_ready       = 1'b1;
        m_first_valid = 1'b0;
        m_first       = '0;
        seed          = 32'd86125;
        tname         = "reset";
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        compare_state();

        tname = "start_glitch";
        press_start(1'b0);
        tname = "to_preview";
        press_start(1'b1);
        wait_centres("preview_colours");
        tname = "to_play";
        press_start(1'b1);
        wait_centres("play_backs");

        // Seven rounds match at most seven pairs, so some cards stay face down
        tname = "play_random";
        repeat (7) begin
            play_round();
        end

        hint_i    = 1'b1;
        tname     = "hint_picks";
        hint_card = unmatched_card();
        do_pick(hint_card);
        do_pick(hint_card ^ 4'd8);
        wait_centres("hint_colours");
        hint_i = 1'b0;
        wait_centres("hint_release");

        tname = "play_random";
        repeat (33) begin
            play_round();
        end

        tname = "to_finish";
        press_start(1'b1);
        wait_centres("finish_colours");
        tname = "to_idle";
        press_start(1'b1);

        total = state_errs + pixel_errs + u_dut.u_props.err_total;
        $display("Errors: state %0d, pixel %0d, assertion %0d",
                 state_errs, pixel_errs, u_dut.u_props.err_total);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/memory_game_pkg.sv
source/button_conditioner.sv
source/vga_timing.sv
source/card_board.sv
source/pixel_compose.sv
source/memory_game_top.sv
verification/memory_game_props.sv
verification/memory_game_tb.sv
